/* cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluPassB
    } aluOpT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4
    } resultSrcT;

    // Memory map.
    localparam wordT    resetPc   = 32'h0000_0000;
    localparam int      imemWords = 64;
    localparam int      dmemWords = 64;
    localparam wordT    ioAddr    = 32'h0000_0100;
    localparam regAddrT a0Index   = 5'd10;

    // addi x0, x0, 0
    localparam wordT nopInstr = 32'h0000_0013;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

endpackage

/* alu.sv */
`timescale 1ns/100ps

module alu import cpuPkg::*;
(
    input  wordT  a,
    input  wordT  b,
    input  aluOpT op,
    output wordT  y,
    output logic  zero,
    output logic  lessThan
);

    // Signed compare serves slt, blt and bge.
    assign lessThan = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            aluAdd:   y = a + b;
            aluSub:   y = a - b;
            aluAnd:   y = a & b;
            aluOr:    y = a | b;
            aluXor:   y = a ^ b;
            aluSlt:   y = {31'b0, lessThan};
            aluSll:   y = a << b[4:0];
            aluSrl:   y = a >> b[4:0];
            aluPassB: y = b;
            default:  y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

/* dataMem.sv */
`timescale 1ns/100ps

module dataMem import cpuPkg::*;
(
    input  logic clk,
    input  wordT addr,
    input  wordT wdata,
    input  logic we,
    input  wordT ioin,
    output wordT rdata
);

    wordT ram [dmemWords];

    logic [$clog2(dmemWords)-1:0] wordIdx;
    logic                         ioSel;

    assign wordIdx = addr[$clog2(dmemWords)+1:2];
    assign ioSel   = (addr == ioAddr);

    // The input port is read-only.
    always_ff @(posedge clk)
    begin
        if (we && !ioSel)
        begin
            ram[wordIdx] <= wdata;
        end
    end

    assign rdata = ioSel ? ioin : ram[wordIdx];

endmodule

/* regFile.sv */
`timescale 1ns/100ps

module regFile import cpuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regAddrT rs1,
    input  regAddrT rs2,
    output wordT    rd1,
    output wordT    rd2,
    input  logic    we,
    input  regAddrT wa,
    input  wordT    wd,
    output wordT    a0
);

    wordT regs [32];
    logic writeHit;

    assign writeHit = we && (wa != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (writeHit)
        begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is passed straight to the decode read.
    assign rd1 = (writeHit && (wa == rs1)) ? wd : regs[rs1];
    assign rd2 = (writeHit && (wa == rs2)) ? wd : regs[rs2];

    assign a0 = regs[a0Index];

endmodule

/* decoder.sv */
`timescale 1ns/100ps

module decoder import cpuPkg::*;
(
    input  wordT       instr,
    output regAddrT    rs1,
    output regAddrT    rs2,
    output regAddrT    rd,
    output logic       regWrite,
    output logic       memWrite,
    output logic       aluSrc,
    output logic       branch,
    output logic       jump,
    output logic       jalr,
    output aluOpT      aluOp,
    output resultSrcT  resultSrc,
    output logic [2:0] funct3,
    output wordT       immExt
);

    logic [6:0] opcode;
    logic       subtract;
    aluOpT      arithOp;
    immSrcT     immSrc;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    // Only register-register forms carry sub in funct7.
    assign subtract = (opcode == opOp) && instr[30];

    always_comb
    begin
        case (funct3)
            3'b000:  arithOp = subtract ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = aluSrl;
            3'b110:  arithOp = aluOr;
            3'b111:  arithOp = aluAnd;
            default: arithOp = aluAdd;
        endcase
    end

    always_comb
    begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluSrc    = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        aluOp     = aluAdd;
        resultSrc = resAlu;
        immSrc    = immI;
        case (opcode)
            opLoad:
            begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = resMem;
            end
            opStore:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immS;
            end
            opOp:
            begin
                regWrite = 1'b1;
                aluOp    = arithOp;
            end
            opOpImm:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = arithOp;
            end
            opLui:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluPassB;
                immSrc   = immU;
            end
            opBranch:
            begin
                branch = 1'b1;
                aluOp  = aluSub;
                immSrc = immB;
            end
            opJal:
            begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                resultSrc = resPcPlus4;
                immSrc    = immJ;
            end
            opJalr:
            begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                jalr      = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = resPcPlus4;
            end
            default:
            begin
                // Unknown opcode stays a nop.
                regWrite = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        case (immSrc)
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
            immU:    immExt = {instr[31:12], 12'b0};
            immJ:    immExt = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
            default: immExt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

/* fetchUnit.sv */
`timescale 1ns/100ps

module fetchUnit import cpuPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic redirect,
    input  wordT targetPc,
    output wordT instrD,
    output wordT pcD,
    output wordT pcPlus4D
);

    wordT pcF;
    wordT pcPlus4F;
    wordT instrF;

    wordT rom [imemWords];

    initial
    begin
        $readmemh("programInput.hex", rom);
    end

    // Word index with the byte offset dropped.
    assign instrF   = rom[pcF[$clog2(imemWords)+1:2]];
    assign pcPlus4F = pcF + 32'd4;

    always_ff @(posedge clk)
    begin
        if (rst)
            pcF <= resetPc;
        else if (redirect)
            pcF <= targetPc;
        else
            pcF <= pcPlus4F;
    end

    // Fetch/decode register. A bubble replaces the wrong-path fetch.
    always_ff @(posedge clk)
    begin
        if (rst || redirect)
        begin
            instrD <= nopInstr;
        end
        else
        begin
            instrD <= instrF;
        end
        pcD      <= pcF;
        pcPlus4D <= pcPlus4F;
    end

endmodule

/* executeStage.sv */
`timescale 1ns/100ps

module executeStage import cpuPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  wordT       pcD,
    input  wordT       pcPlus4D,
    input  logic       regWriteD,
    input  logic       memWriteD,
    input  logic       aluSrcD,
    input  aluOpT      aluOpD,
    input  resultSrcT  resultSrcD,
    input  logic       branchD,
    input  logic       jumpD,
    input  logic       jalrD,
    input  logic [2:0] funct3D,
    input  wordT       immExtD,
    input  wordT       rd1D,
    input  wordT       rd2D,
    input  regAddrT    rdD,
    output wordT       srcA,
    output wordT       srcB,
    output aluOpT      aluOp,
    input  wordT       aluResult,
    input  logic       zero,
    input  logic       lessThan,
    output wordT       memAddr,
    output wordT       memWData,
    output logic       memWe,
    input  wordT       readData,
    output logic       weE,
    output regAddrT    rdE,
    output wordT       result,
    output logic       redirect,
    output wordT       targetPc
);

    logic       regWriteE;
    logic       memWriteE;
    logic       branchE;
    logic       jumpE;
    logic       jalrE;
    logic       aluSrcE;
    resultSrcT  resultSrcE;
    logic [2:0] funct3E;
    wordT       pcE;
    wordT       pcPlus4E;
    wordT       immExtE;
    wordT       rd1E;
    wordT       rd2E;
    logic       taken;

    // Decode/execute register. Control is cleared to a bubble on flush.
    always_ff @(posedge clk)
    begin
        if (rst || redirect)
        begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
            jumpE     <= 1'b0;
            jalrE     <= 1'b0;
        end
        else
        begin
            regWriteE <= regWriteD;
            memWriteE <= memWriteD;
            branchE   <= branchD;
            jumpE     <= jumpD;
            jalrE     <= jalrD;
        end
        aluSrcE    <= aluSrcD;
        aluOp      <= aluOpD;
        resultSrcE <= resultSrcD;
        funct3E    <= funct3D;
        pcE        <= pcD;
        pcPlus4E   <= pcPlus4D;
        immExtE    <= immExtD;
        rd1E       <= rd1D;
        rd2E       <= rd2D;
        rdE        <= rdD;
    end

    assign srcA = rd1E;
    assign srcB = aluSrcE ? immExtE : rd2E;

    assign memAddr  = aluResult;
    assign memWData = rd2E;
    assign memWe    = memWriteE;

    always_comb
    begin
        case (funct3E)
            3'b000:  taken = zero;
            3'b001:  taken = !zero;
            3'b100:  taken = lessThan;
            3'b101:  taken = !lessThan;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = jumpE || (branchE && taken);
    // jalr target comes from the ALU sum with bit 0 cleared.
    assign targetPc = jalrE ? {aluResult[31:1], 1'b0} : pcE + immExtE;

    assign weE = regWriteE;

    always_comb
    begin
        case (resultSrcE)
            resMem:     result = readData;
            resPcPlus4: result = pcPlus4E;
            default:    result = aluResult;
        endcase
    end

endmodule

/* cpu.sv */
`timescale 1ns/100ps

module cpu import cpuPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  wordT ioin,
    output wordT a0
);

    // Fetch to decode.
    wordT instrD;
    wordT pcD;
    wordT pcPlus4D;

    // Decode outputs.
    regAddrT   rs1;
    regAddrT   rs2;
    regAddrT   rd;
    logic      regWriteD;
    logic      memWriteD;
    logic      aluSrcD;
    logic      branchD;
    logic      jumpD;
    logic      jalrD;
    aluOpT     aluOpD;
    resultSrcT resultSrcD;
    logic [2:0] funct3D;
    wordT      immExtD;
    wordT      rd1;
    wordT      rd2;

    // Execute.
    wordT    srcA;
    wordT    srcB;
    aluOpT   aluOpE;
    wordT    aluResult;
    logic    zero;
    logic    lessThan;
    wordT    memAddr;
    wordT    memWData;
    logic    memWe;
    wordT    readData;
    logic    weE;
    regAddrT rdE;
    wordT    result;
    logic    redirect;
    wordT    targetPc;

    fetchUnit fetchUnit_i (
        .clk(clk), .rst(rst), .redirect(redirect), .targetPc(targetPc),
        .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D)
    );

    decoder decoder_i (
        .instr(instrD), .rs1(rs1), .rs2(rs2), .rd(rd),
        .regWrite(regWriteD), .memWrite(memWriteD), .aluSrc(aluSrcD),
        .branch(branchD), .jump(jumpD), .jalr(jalrD), .aluOp(aluOpD),
        .resultSrc(resultSrcD), .funct3(funct3D), .immExt(immExtD)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
        .we(weE), .wa(rdE), .wd(result), .a0(a0)
    );

    executeStage executeStage_i (
        .clk(clk), .rst(rst), .pcD(pcD), .pcPlus4D(pcPlus4D),
        .regWriteD(regWriteD), .memWriteD(memWriteD), .aluSrcD(aluSrcD),
        .aluOpD(aluOpD), .resultSrcD(resultSrcD), .branchD(branchD),
        .jumpD(jumpD), .jalrD(jalrD), .funct3D(funct3D), .immExtD(immExtD),
        .rd1D(rd1), .rd2D(rd2), .rdD(rd),
        .srcA(srcA), .srcB(srcB), .aluOp(aluOpE),
        .aluResult(aluResult), .zero(zero), .lessThan(lessThan),
        .memAddr(memAddr), .memWData(memWData), .memWe(memWe), .readData(readData),
        .weE(weE), .rdE(rdE), .result(result),
        .redirect(redirect), .targetPc(targetPc)
    );

    alu alu_i (
        .a(srcA), .b(srcB), .op(aluOpE), .y(aluResult), .zero(zero), .lessThan(lessThan)
    );

    dataMem dataMem_i (
        .clk(clk), .addr(memAddr), .wdata(memWData), .we(memWe),
        .ioin(ioin), .rdata(readData)
    );

endmodule

/* cpu_properties.sv */
`timescale 1ns/100ps

module cpuProperties import cpuPkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      redirect,
    input logic      weE,
    input regAddrT   rdE,
    input resultSrcT resultSrcE,
    input wordT      result,
    input logic      memWe
);

    // A transfer flushes the slot behind it, so it cannot redirect again.
    redirectSingle: assert property (
        @(posedge clk) disable iff (rst)
        redirect |=> !redirect
    ) else $error("redirect was high in two consecutive cycles");

    // Writes aimed at x0 come only from bubbles or from discarded links.
    x0WriteHarmless: assert property (
        @(posedge clk) disable iff (rst)
        (weE && rdE == '0) |-> (resultSrcE == resPcPlus4 || result == '0)
    ) else $error("write to x0 carried a value %h", result);

    // The first reset edge loads the bubble into the execute slot.
    noStoreInReset: assert property (
        @(posedge clk)
        (rst && $past(rst)) |-> !memWe
    ) else $error("store enable was high during reset");

endmodule

bind executeStage cpuProperties cpuProperties_i (
    .clk(clk),
    .rst(rst),
    .redirect(redirect),
    .weE(weE),
    .rdE(rdE),
    .resultSrcE(resultSrcE),
    .result(result),
    .memWe(memWe)
);

/* cpuTb.sv */
`timescale 1ns/100ps

module cpuTb import cpuPkg::*;
();

    localparam int resetCycles  = 8;
    // Longest pass through the polling loop including bubbles.
    localparam int loopCycles   = 17;
    // A load can just miss the new value, so the next pass carries it to a0.
    localparam int settleCycles = 2 * loopCycles + 4;
    localparam int maxGap       = 7;
    localparam int marginCycles = 50;

    logic clk;
    logic rst;
    wordT ioin;
    wordT a0;

    logic [255:0] nameQ [$];
    wordT         ioinQ [$];
    wordT         expectQ [$];

    int cycleCount   = 0;
    int cycleLimit   = 0;
    bit passReported = 1'b0;
    bit failReported = 1'b0;

    cpu dut_i (
        .clk(clk),
        .rst(rst),
        .ioin(ioin),
        .a0(a0)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkValue(input logic [255:0] testName, input wordT expected,
                              input wordT actual);
        if (actual !== expected)
        begin
            $display("Mismatch %0s expected %h got %h", testName, expected, actual);
            failReported = 1'b1;
            $display("Simulation finished: FAIL");
            $fatal(1, "a0 value check failed");
        end
    endtask

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: program did not settle");
            failReported = 1'b1;
            $display("Simulation finished: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    initial
    begin
        int           fd;
        int           fields;
        string        line;
        logic [255:0] nameBuf;
        wordT         ioinVal;
        wordT         expectVal;
        int unsigned  gap;

        rst  = 1'b1;
        ioin = '0;
        void'($urandom(32'hb5f60204));

        fd = $fopen("vectorsInput.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file vectorsInput.txt");
            failReported = 1'b1;
            $display("Simulation finished: FAIL");
            $fatal(1, "missing vector file");
        end
        while ($fgets(line, fd) != 0)
        begin
            // Blank and comment lines carry no vector.
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                fields = $sscanf(line, "%s %h %h", nameBuf, ioinVal, expectVal);
                if (fields != 3)
                begin
                    $display("Vector line could not be parsed: %s", line);
                    failReported = 1'b1;
                    $display("Simulation finished: FAIL");
                    $fatal(1, "malformed vector line");
                end
                nameQ.push_back(nameBuf);
                ioinQ.push_back(ioinVal);
                expectQ.push_back(expectVal);
            end
        end
        $fclose(fd);
        cycleLimit = nameQ.size() * (settleCycles + maxGap + 2) + resetCycles + marginCycles;

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("after_reset", '0, a0);

        foreach (ioinQ[i])
        begin
            gap = $urandom % (maxGap + 1);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            ioin <= ioinQ[i];
            repeat (settleCycles) @(posedge clk);
            @(negedge clk);
            checkValue(nameQ[i], expectQ[i], a0);
        end

        passReported = 1'b1;
        $display("Simulation finished: PASS");
        $finish;
    end

    final
    begin
        if (!passReported && !failReported)
        begin
            $display("Simulation finished: FAIL");
        end
    end

endmodule

/* programInput.hex */
// One instruction word per line, starting at address 0.
// Polls ioin, round-trips it through RAM and sets a0 from a subroutine.
10002283 // 00: lw   x5, 256(x0)
00502023 // 04: sw   x5, 0(x0)
00002303 // 08: lw   x6, 0(x0)
00c000ef // 0c: jal  x1, 0x18
00038533 // 10: add  x10, x7, x0
fedff06f // 14: jal  x0, 0x00
00034a63 // 18: blt  x6, x0, 0x2c
00131393 // 1c: slli x7, x6, 1
006383b3 // 20: add  x7, x7, x6
00738393 // 24: addi x7, x7, 7
00008067 // 28: jalr x0, 0(x1)
0ff34393 // 2c: xori x7, x6, 0xff
00008067 // 30: jalr x0, 0(x1)
00000013 // 34: nop
00000013 // 38: nop
00000013 // 3c: nop

/* vectorsInput.txt */
# name  ioin (hex)  expected a0 (hex)
# a0 is 3*ioin+7 when ioin is non-negative as signed, else ioin xor 0xff
zero          00000000  00000007
small_one     00000001  0000000a
neg_one       ffffffff  ffffff00
small_five    00000005  00000016
neg_small     fffffff0  ffffff0f
small_hundred 00000064  00000133
alt_neg       80001234  800012cb
alt_pos       00001234  000036a3
min_neg       80000000  800000ff
high_pos      7ffffff0  7fffffd7
high_bits     40000000  c0000007

/* project.f */
cpuPkg.sv
alu.sv
dataMem.sv
regFile.sv
decoder.sv
fetchUnit.sv
executeStage.sv
cpu.sv
cpu_properties.sv
cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation finished: FAIL" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
